//--- Bender.yml
package:
  name: window_detector

sources:
  - win_pkg.sv
  - sample_history.sv
  - axis_out_reg.sv
  - moving_sum.sv
  - power_sum.sv
  - stats_join.sv
  - wb_cfg_regs.sv
  - window_detector_top.sv
  - target: test
    files:
      - tb_window_detector.sv

//--- axis_out_reg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// two-entry stream register, one cycle latency.
// o_ready depends on occupancy only.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module axis_out_reg #(
  parameter int DATA_W = 8
) (
  input  logic              clk,
  input  logic              i_rst,
  input  logic              i_clear,
  input  logic [DATA_W-1:0] i_data,
  input  logic              i_valid,
  output logic              o_ready,
  output logic [DATA_W-1:0] o_data,
  output logic              o_valid,
  input  logic              i_ready
);

  logic [1:0]        count;
  logic [DATA_W-1:0] spare;
  logic              push, pop;

  assign o_ready = (count != 2'd2);
  assign o_valid = (count != 2'd0);
  assign push    = i_valid & o_ready;
  assign pop     = o_valid & i_ready;

  always_ff @(posedge clk) begin
    if (i_rst || i_clear) begin
      count <= 2'd0;
    end else if (push && !pop) begin
      count <= count + 2'd1;
    end else if (pop && !push) begin
      count <= count - 2'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (push && (count == 2'd0 || (count == 2'd1 && pop))) begin
      o_data <= i_data;
    end else if (pop && count == 2'd2) begin
      o_data <= spare; // spare moves up to the head.
    end
    if (push && count == 2'd1 && !pop) begin
      spare <= i_data;
    end
  end

endmodule

//--- moving_sum.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// signed windowed sum; a length change flushes
// the window and stalls the input for one cycle.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module moving_sum #(
  parameter int SAMPLE_W = win_pkg::SAMPLE_W,
  parameter int MAX_LEN  = win_pkg::MAX_LEN
) (
  input  logic                                  clk,
  input  logic                                  i_rst,
  input  logic                                  i_clear,
  input  logic [$clog2(MAX_LEN+1)-1:0]          i_len,
  input  logic [SAMPLE_W-1:0]                   i_data,
  input  logic                                  i_last,
  input  logic                                  i_valid,
  output logic                                  o_ready,
  output logic [SAMPLE_W+$clog2(MAX_LEN+1)-1:0] o_sum,
  output logic                                  o_last,
  output logic                                  o_valid,
  input  logic                                  i_ready
);

  localparam int LEN_W = $clog2(MAX_LEN + 1);
  localparam int SUM_W = SAMPLE_W + LEN_W;

  logic [LEN_W-1:0]        len_reg;
  logic                    len_chg;
  logic [LEN_W-1:0]        fill_cnt;
  logic signed [SUM_W-1:0] sum_reg;
  logic signed [SUM_W-1:0] sum_next;
  logic signed [SUM_W-1:0] new_ext;
  logic signed [SUM_W-1:0] old_ext;
  logic signed [SUM_W-1:0] old_term;
  logic [SAMPLE_W-1:0]     oldest;
  logic                    full, flush, accept, out_rdy;

  assign full   = (fill_cnt == len_reg);
  assign flush  = len_chg | i_clear;
  assign o_ready = out_rdy & ~flush;
  assign accept = i_valid & o_ready;

  // both extend by sign before the add.
  assign new_ext  = $signed(i_data);
  assign old_ext  = $signed(oldest);
  assign old_term = full ? old_ext : '0;
  assign sum_next = sum_reg + new_ext - old_term;

  always_ff @(posedge clk) begin
    if (i_rst) begin
      len_reg <= LEN_W'(1);
      len_chg <= 1'b0;
    end else begin
      len_reg <= i_len;
      len_chg <= (i_len != len_reg);
    end
  end

  always_ff @(posedge clk) begin
    if (i_rst || flush) begin
      sum_reg  <= '0;
      fill_cnt <= '0;
    end else if (accept) begin
      sum_reg <= sum_next;
      if (!full) begin
        fill_cnt <= fill_cnt + 1'b1; // stops at the window length.
      end
    end
  end

  sample_history #(
    .SAMPLE_W (SAMPLE_W),
    .MAX_LEN  (MAX_LEN)
  ) sample_history_inst (
    .clk      (clk),
    .i_rst    (i_rst),
    .i_flush  (flush),
    .i_len    (len_reg),
    .i_push   (accept),
    .i_data   (i_data),
    .o_oldest (oldest)
  );

  axis_out_reg #(
    .DATA_W  (SUM_W + 1)
  ) axis_out_reg_inst (
    .clk     (clk),
    .i_rst   (i_rst),
    .i_clear (i_clear),
    .i_data  ({i_last, sum_next}),
    .i_valid (i_valid & ~flush),
    .o_ready (out_rdy),
    .o_data  ({o_last, o_sum}),
    .o_valid (o_valid),
    .i_ready (i_ready)
  );

endmodule

//--- power_sum.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// windowed sum of squares, no last marker.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module power_sum #(
  parameter int SAMPLE_W = win_pkg::SAMPLE_W,
  parameter int MAX_LEN  = win_pkg::MAX_LEN
) (
  input  logic                                    clk,
  input  logic                                    i_rst,
  input  logic                                    i_clear,
  input  logic [$clog2(MAX_LEN+1)-1:0]            i_len,
  input  logic [SAMPLE_W-1:0]                     i_data,
  input  logic                                    i_valid,
  output logic                                    o_ready,
  output logic [2*SAMPLE_W+$clog2(MAX_LEN+1)-1:0] o_pow,
  output logic                                    o_valid,
  input  logic                                    i_ready
);

  localparam int SQ_W = 2 * SAMPLE_W;

  logic [SQ_W-1:0] square;

  // top bit is always clear, so the signed sum below is safe.
  assign square = $signed(i_data) * $signed(i_data);

  moving_sum #(
    .SAMPLE_W (SQ_W),
    .MAX_LEN  (MAX_LEN)
  ) moving_sum_inst (
    .clk     (clk),
    .i_rst   (i_rst),
    .i_clear (i_clear),
    .i_len   (i_len),
    .i_data  (square),
    .i_last  (1'b0),
    .i_valid (i_valid),
    .o_ready (o_ready),
    .o_sum   (o_pow),
    .o_last  (),
    .o_valid (o_valid),
    .i_ready (i_ready)
  );

endmodule

//--- sample_history.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// i_len must stay within 1..MAX_LEN.
// o_oldest is only meaningful once the window is full.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module sample_history #(
  parameter int SAMPLE_W = win_pkg::SAMPLE_W,
  parameter int MAX_LEN  = win_pkg::MAX_LEN
) (
  input  logic                         clk,
  input  logic                         i_rst,
  input  logic                         i_flush,
  input  logic [$clog2(MAX_LEN+1)-1:0] i_len,
  input  logic                         i_push,
  input  logic [SAMPLE_W-1:0]          i_data,
  output logic [SAMPLE_W-1:0]          o_oldest
);

  localparam int LEN_W = $clog2(MAX_LEN + 1);

  logic [SAMPLE_W-1:0] mem [MAX_LEN];
  logic [LEN_W-1:0]    wr_ptr;
  logic                ptr_wrap;

  assign ptr_wrap = (wr_ptr >= i_len - 1'b1); // last slot of the window.
  assign o_oldest = mem[wr_ptr];

  always_ff @(posedge clk) begin
    if (i_rst || i_flush) begin
      wr_ptr <= '0;
    end else if (i_push) begin
      wr_ptr <= ptr_wrap ? '0 : wr_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (i_push) begin
      mem[wr_ptr] <= i_data;
    end
  end

endmodule

//--- src.f
win_pkg.sv
sample_history.sv
axis_out_reg.sv
moving_sum.sv
power_sum.sv
stats_join.sv
wb_cfg_regs.sv
window_detector_top.sv
tb_window_detector.sv

//--- stats_join.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fork/join around the two branches.
// metric = len * sum(x^2) - sum(x)^2, never negative.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module stats_join #(
  parameter int SAMPLE_W = win_pkg::SAMPLE_W,
  parameter int MAX_LEN  = win_pkg::MAX_LEN
) (
  input  logic                                      clk,
  input  logic                                      i_rst,
  input  logic                                      i_clear,
  input  logic [$clog2(MAX_LEN+1)-1:0]              i_len,
  input  logic [win_pkg::THRESH_W-1:0]              i_thresh,
  input  logic                                      i_tvalid,
  output logic                                      o_tready,
  output logic                                      o_mean_valid,
  output logic                                      o_pow_valid,
  input  logic                                      i_mean_ready,
  input  logic                                      i_pow_ready,
  input  logic [SAMPLE_W+$clog2(MAX_LEN+1)-1:0]     i_mean,
  input  logic                                      i_mean_last,
  input  logic                                      i_mean_vld,
  output logic                                      o_mean_pop,
  input  logic [2*SAMPLE_W+$clog2(MAX_LEN+1)-1:0]   i_pow,
  input  logic                                      i_pow_vld,
  output logic                                      o_pow_pop,
  output logic [2*(SAMPLE_W+$clog2(MAX_LEN+1))-1:0] o_metric,
  output logic                                      o_detect,
  output logic                                      o_tlast,
  output logic                                      o_tvalid,
  input  logic                                      i_tready,
  output logic                                      o_detect_event
);

  localparam int LEN_W    = $clog2(MAX_LEN + 1);
  localparam int METRIC_W = 2 * (SAMPLE_W + LEN_W);

  logic [METRIC_W-1:0]        len_pow;
  logic signed [METRIC_W-1:0] mean_sq;
  logic [METRIC_W-1:0]        metric;
  logic                       detect, room, pop;

  // fork. each branch only sees valid when the other can take it too.
  assign o_mean_valid = i_tvalid & i_pow_ready;
  assign o_pow_valid  = i_tvalid & i_mean_ready;
  assign o_tready     = i_mean_ready & i_pow_ready;

  // join.
  assign room       = ~o_tvalid | i_tready;
  assign pop        = i_mean_vld & i_pow_vld & room;
  assign o_mean_pop = pop;
  assign o_pow_pop  = pop;

  assign len_pow = i_len * i_pow;
  assign mean_sq = $signed(i_mean) * $signed(i_mean);
  assign metric  = len_pow - mean_sq;
  assign detect  = (metric > i_thresh); // threshold zero-extends.

  always_ff @(posedge clk) begin
    if (i_rst || i_clear) begin
      o_tvalid <= 1'b0;
      o_detect <= 1'b0;
    end else if (pop) begin
      o_tvalid <= 1'b1;
      o_detect <= detect;
    end else if (i_tready) begin
      o_tvalid <= 1'b0;
      o_detect <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      o_metric <= metric;
      o_tlast  <= i_mean_last;
    end
  end

  assign o_detect_event = o_tvalid & i_tready & o_detect;

endmodule

//--- tb_window_detector.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// self-checking bench, default parameters only.
// outputs are drained before every register access.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module tb_window_detector;

  import win_pkg::*;

  localparam int CLK_PERIOD = 4;
  localparam int NROWS      = 6;
  localparam int K_RAND     = 0;
  localparam int K_CONST    = 1;
  localparam int K_ALT      = 2;

  typedef struct packed {
    int          len;
    logic [31:0] thresh;
    int          count;
    int          amp;
    logic        bp;
    int          kind;
  } row_t;

  logic                clk;
  logic                i_rst;
  logic [SAMPLE_W-1:0] i_tdata;
  logic                i_tlast;
  logic                i_tvalid;
  logic                o_tready_in;
  logic [METRIC_W-1:0] o_metric;
  logic                o_detect;
  logic                o_tlast;
  logic                o_tvalid;
  logic                i_out_ready;
  logic                i_wb_cyc;
  logic                i_wb_stb;
  logic                i_wb_we;
  logic [1:0]          i_wb_adr;
  logic [31:0]         i_wb_dat;
  logic [31:0]         o_wb_dat;
  logic                o_wb_ack;

  row_t                rows [NROWS];
  int                  total_samples = 0;
  int                  mismatch_cnt = 0;
  int                  fail_cnt = 0;
  int                  model_len = 1;    // reset length.
  logic [31:0]         model_thresh = '0;
  int                  win_q [$];
  logic [METRIC_W-1:0] exp_metric_q [$];
  logic                exp_detect_q [$];
  logic                exp_last_q [$];
  int                  exp_count = 0;
  logic                bp_on = 1'b0;

  window_detector_top window_detector_top_inst (
    .clk         (clk),
    .i_rst       (i_rst),
    .i_tdata     (i_tdata),
    .i_tlast     (i_tlast),
    .i_tvalid    (i_tvalid),
    .o_tready_in (o_tready_in),
    .o_metric    (o_metric),
    .o_detect    (o_detect),
    .o_tlast     (o_tlast),
    .o_tvalid    (o_tvalid),
    .i_out_ready (i_out_ready),
    .i_wb_cyc    (i_wb_cyc),
    .i_wb_stb    (i_wb_stb),
    .i_wb_we     (i_wb_we),
    .i_wb_adr    (i_wb_adr),
    .i_wb_dat    (i_wb_dat),
    .o_wb_dat    (o_wb_dat),
    .o_wb_ack    (o_wb_ack)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic check_metric(input logic [METRIC_W-1:0] exp, input logic [METRIC_W-1:0] act);
    if (act !== exp) begin
      mismatch_cnt++;
      $display("MISMATCH time=%0t signal=o_metric expected=%0d actual=%0d", $time, exp, act);
    end
  endtask

  task automatic check_detect(input logic exp, input logic act);
    if (act !== exp) begin
      mismatch_cnt++;
      $display("MISMATCH time=%0t signal=o_detect expected=%b actual=%b", $time, exp, act);
    end
  endtask

  task automatic check_last(input logic exp, input logic act);
    if (act !== exp) begin
      mismatch_cnt++;
      $display("MISMATCH time=%0t signal=o_tlast expected=%b actual=%b", $time, exp, act);
    end
  endtask

  task automatic check_wb(input string reg_name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      mismatch_cnt++;
      $display("MISMATCH time=%0t signal=o_wb_dat(%s) expected=%0d actual=%0d",
               $time, reg_name, exp, act);
    end
  endtask

  task automatic report_failure(input string what);
    fail_cnt++;
    $display("ERROR time=%0t %s", $time, what);
  endtask

  function automatic int clamp_len(input int len);
    if (len <= 0) begin
      return 1;
    end
    if (len > MAX_LEN) begin
      return MAX_LEN;
    end
    return len;
  endfunction

  // reference model, one call per accepted sample.
  task automatic model_push(input int x, input logic last);
    longint              s;
    longint              p;
    longint              m;
    logic [METRIC_W-1:0] metric;
    logic                det;
    win_q.push_back(x);
    if (win_q.size() > model_len) begin
      win_q.delete(0);
    end
    s = 0;
    p = 0;
    foreach (win_q[i]) begin
      s += win_q[i];
      p += longint'(win_q[i]) * win_q[i];
    end
    m = longint'(model_len) * p - s * s; // full length even while filling.
    metric = m[METRIC_W-1:0];
    det = (metric > METRIC_W'(model_thresh));
    if (det) begin
      exp_count++;
    end
    exp_metric_q.push_back(metric);
    exp_detect_q.push_back(det);
    exp_last_q.push_back(last);
  endtask

  task automatic wb_access(input logic we, input logic [1:0] adr, input logic [31:0] dat,
                           output logic [31:0] rdata);
    int waits;
    @(negedge clk);
    i_wb_cyc = 1'b1;
    i_wb_stb = 1'b1;
    i_wb_we  = we;
    i_wb_adr = adr;
    i_wb_dat = dat;
    waits = 0;
    @(negedge clk);
    while (o_wb_ack !== 1'b1 && waits < 8) begin
      @(negedge clk);
      waits++;
    end
    if (waits != 0) begin
      report_failure("wishbone ack did not come one cycle after the request");
    end
    rdata = o_wb_dat;
    i_wb_cyc = 1'b0;
    i_wb_stb = 1'b0;
    i_wb_we  = 1'b0;
    @(negedge clk);
    if (o_wb_ack !== 1'b0) begin
      report_failure("wishbone ack stayed high for more than one cycle");
    end
  endtask

  task automatic send_sample(input int x, input logic last);
    @(negedge clk);
    i_tdata  = x[SAMPLE_W-1:0];
    i_tlast  = last;
    i_tvalid = 1'b1;
    while (o_tready_in !== 1'b1) begin
      @(negedge clk);
    end
    model_push(x, last); // taken on the next rising edge.
  endtask

  task automatic idle_stream();
    @(negedge clk);
    i_tvalid = 1'b0;
    i_tlast  = 1'b0;
  endtask

  task automatic drain_outputs();
    while (exp_metric_q.size() != 0) begin
      @(negedge clk);
    end
    repeat (3) @(negedge clk);
  endtask

  task automatic clear_and_check();
    logic [31:0] rd;
    drain_outputs();
    wb_access(1'b0, REG_COUNT, '0, rd);
    check_wb("count", 32'(exp_count), rd);
    wb_access(1'b1, REG_CTRL, 32'd1, rd);
    win_q.delete();
    exp_count = 0;
    repeat (2) @(negedge clk);
    wb_access(1'b0, REG_COUNT, '0, rd);
    check_wb("count", 32'd0, rd);
  endtask

  task automatic load_table();
    rows[0] = '{4, 32'd10_000_000, 40, 2000, 1'b0, K_RAND};
    rows[1] = '{4, 32'd100, 16, 500, 1'b0, K_CONST};     // same length, no flush.
    rows[2] = '{8, 32'd1000, 24, 3000, 1'b1, K_ALT};
    rows[3] = '{6, 32'hC000_0000, 60, 30000, 1'b1, K_RAND};
    rows[4] = '{300, 32'hFFFF_FFFF, 300, 32767, 1'b1, K_RAND}; // clamps to MAX_LEN.
    rows[5] = '{0, 32'd0, 10, 1000, 1'b0, K_RAND};          // used as 1.
    for (int i = 0; i < NROWS; i++) begin
      total_samples += rows[i].count;
    end
  endtask

  // output side: ready pattern and result checks.
  always @(negedge clk) begin
    if (bp_on) begin
      i_out_ready = ($urandom_range(3) != 0);
    end else begin
      i_out_ready = 1'b1;
    end
    if (o_tvalid === 1'b1 && i_out_ready) begin
      if (exp_metric_q.size() == 0) begin
        report_failure("output transfer with no result expected");
      end else begin
        check_metric(exp_metric_q.pop_front(), o_metric);
        check_detect(exp_detect_q.pop_front(), o_detect);
        check_last(exp_last_q.pop_front(), o_tlast);
      end
    end
  end

  initial begin
    wait (total_samples > 0);
    #((total_samples * 20 + 1000) * CLK_PERIOD);
    report_failure("watchdog fired, the run timed out");
    $display("summary: %0d mismatches, %0d other errors", mismatch_cnt, fail_cnt);
    $display("** FAIL **");
    $finish;
  end

  initial begin
    logic [31:0] rd;
    int          x;
    int          new_len;
    void'($urandom(71588));
    i_rst       = 1'b1;
    i_tdata     = '0;
    i_tlast     = 1'b0;
    i_tvalid    = 1'b0;
    i_out_ready = 1'b1;
    i_wb_cyc    = 1'b0;
    i_wb_stb    = 1'b0;
    i_wb_we     = 1'b0;
    i_wb_adr    = '0;
    i_wb_dat    = '0;
    load_table();
    repeat (2) @(posedge clk);
    @(negedge clk);
    i_rst = 1'b0;

    if (o_tvalid !== 1'b0 || o_wb_ack !== 1'b0) begin
      report_failure("stream or wishbone outputs not idle after reset");
    end
    check_detect(1'b0, o_detect);
    wb_access(1'b0, REG_LEN, '0, rd);
    check_wb("len", 32'd1, rd);
    wb_access(1'b0, REG_THRESH, '0, rd);
    check_wb("thresh", 32'd0, rd);

    for (int r = 0; r < NROWS; r++) begin
      drain_outputs();
      wb_access(1'b1, REG_THRESH, rows[r].thresh, rd);
      wb_access(1'b1, REG_LEN, rows[r].len, rd);
      new_len = clamp_len(rows[r].len);
      if (new_len != model_len) begin
        model_len = new_len;
        win_q.delete(); // new length restarts the window.
      end
      model_thresh = rows[r].thresh;
      wb_access(1'b0, REG_LEN, '0, rd);
      check_wb("len", 32'(new_len), rd);
      bp_on = rows[r].bp;
      repeat (4) @(negedge clk);
      for (int k = 0; k < rows[r].count; k++) begin
        case (rows[r].kind)
          K_RAND:  x = int'($urandom_range(2 * rows[r].amp)) - rows[r].amp;
          K_CONST: x = rows[r].amp;
          default: x = (k % 2 == 0) ? rows[r].amp : -rows[r].amp;
        endcase
        send_sample(x, (k % 5 == 4) || (k == rows[r].count - 1));
      end
      idle_stream();
      if (r == 0) begin
        clear_and_check();
      end
    end

    drain_outputs();
    wb_access(1'b0, REG_COUNT, '0, rd);
    check_wb("count", 32'(exp_count), rd);
    $display("summary: %0d mismatches, %0d other errors", mismatch_cnt, fail_cnt);
    if (mismatch_cnt == 0 && fail_cnt == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

//--- wb_cfg_regs.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// classic wishbone, ack one cycle after the request.
// length writes clamp to 1..MAX_LEN.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module wb_cfg_regs #(
  parameter int MAX_LEN = win_pkg::MAX_LEN
) (
  input  logic                         clk,
  input  logic                         i_rst,
  input  logic                         i_wb_cyc,
  input  logic                         i_wb_stb,
  input  logic                         i_wb_we,
  input  logic [1:0]                   i_wb_adr,
  input  logic [31:0]                  i_wb_dat,
  output logic [31:0]                  o_wb_dat,
  output logic                         o_wb_ack,
  input  logic                         i_detect_event,
  output logic [$clog2(MAX_LEN+1)-1:0] o_len,
  output logic [win_pkg::THRESH_W-1:0] o_thresh,
  output logic                         o_clear
);

  import win_pkg::*;

  localparam int LEN_W = $clog2(MAX_LEN + 1);
  localparam int CNT_W = 16;

  cfg_addr_e        addr;
  logic             req, wr_en;
  logic [LEN_W-1:0] wr_len;
  logic [CNT_W-1:0] det_cnt;

  assign addr  = cfg_addr_e'(i_wb_adr);
  assign req   = i_wb_cyc & i_wb_stb & ~o_wb_ack; // first cycle of an access.
  assign wr_en = req & i_wb_we;

  always_comb begin
    if (i_wb_dat == '0) begin
      wr_len = LEN_W'(1);
    end else if (i_wb_dat > MAX_LEN) begin
      wr_len = LEN_W'(MAX_LEN);
    end else begin
      wr_len = i_wb_dat[LEN_W-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (i_rst) begin
      o_wb_ack <= 1'b0;
      o_len    <= LEN_W'(1);
      o_thresh <= '0;
      o_clear  <= 1'b0;
    end else begin
      o_wb_ack <= req;
      o_clear  <= wr_en && (addr == REG_CTRL) && i_wb_dat[0];
      if (wr_en) begin
        case (addr)
          REG_LEN:    o_len    <= wr_len;
          REG_THRESH: o_thresh <= i_wb_dat[THRESH_W-1:0];
          default:    ;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_rst || o_clear) begin
      det_cnt <= '0;
    end else if (i_detect_event && det_cnt != '1) begin
      det_cnt <= det_cnt + 1'b1; // saturates.
    end
  end

  always_ff @(posedge clk) begin
    if (req) begin
      case (addr)
        REG_LEN:    o_wb_dat <= 32'(o_len);
        REG_THRESH: o_wb_dat <= 32'(o_thresh);
        REG_COUNT:  o_wb_dat <= 32'(det_cnt);
        default:    o_wb_dat <= '0;
      endcase
    end
  end

endmodule

//--- win_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// default widths for the window detector.
// sums are sized so a full window never overflows.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package win_pkg;

  localparam int SAMPLE_W = 16;
  localparam int MAX_LEN  = 255;
  localparam int LEN_W    = $clog2(MAX_LEN + 1);
  localparam int MEAN_W   = SAMPLE_W + LEN_W;
  localparam int SQ_W     = 2 * SAMPLE_W;
  localparam int POW_W    = SQ_W + LEN_W;
  localparam int METRIC_W = 2 * MEAN_W;
  localparam int THRESH_W = 32;

  // word addresses of the config bank.
  typedef enum logic [1:0] {
    REG_LEN    = 2'd0,
    REG_THRESH = 2'd1,
    REG_CTRL   = 2'd2,
    REG_COUNT  = 2'd3
  } cfg_addr_e;

endpackage

//--- window_detector_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// two cycles from input to output when unstalled.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module window_detector_top #(
  parameter int SAMPLE_W = win_pkg::SAMPLE_W,
  parameter int MAX_LEN  = win_pkg::MAX_LEN
) (
  input  logic                                      clk,
  input  logic                                      i_rst,
  input  logic [SAMPLE_W-1:0]                       i_tdata,
  input  logic                                      i_tlast,
  input  logic                                      i_tvalid,
  output logic                                      o_tready_in,
  output logic [2*(SAMPLE_W+$clog2(MAX_LEN+1))-1:0] o_metric,
  output logic                                      o_detect,
  output logic                                      o_tlast,
  output logic                                      o_tvalid,
  input  logic                                      i_out_ready,
  input  logic                                      i_wb_cyc,
  input  logic                                      i_wb_stb,
  input  logic                                      i_wb_we,
  input  logic [1:0]                                i_wb_adr,
  input  logic [31:0]                               i_wb_dat,
  output logic [31:0]                               o_wb_dat,
  output logic                                      o_wb_ack
);

  import win_pkg::*;

  localparam int LEN_W  = $clog2(MAX_LEN + 1);
  localparam int MEAN_W = SAMPLE_W + LEN_W;
  localparam int POW_W  = 2 * SAMPLE_W + LEN_W;

  logic [LEN_W-1:0]    cfg_len;
  logic [THRESH_W-1:0] cfg_thresh;
  logic                cfg_clear, detect_event;
  logic                mean_valid, mean_ready, mean_last, mean_vld, mean_pop;
  logic                pow_valid, pow_ready, pow_vld, pow_pop;
  logic [MEAN_W-1:0]   mean_sum;
  logic [POW_W-1:0]    pow_sum;

  wb_cfg_regs #(
    .MAX_LEN        (MAX_LEN)
  ) wb_cfg_regs_inst (
    .clk            (clk),
    .i_rst          (i_rst),
    .i_wb_cyc       (i_wb_cyc),
    .i_wb_stb       (i_wb_stb),
    .i_wb_we        (i_wb_we),
    .i_wb_adr       (i_wb_adr),
    .i_wb_dat       (i_wb_dat),
    .o_wb_dat       (o_wb_dat),
    .o_wb_ack       (o_wb_ack),
    .i_detect_event (detect_event),
    .o_len          (cfg_len),
    .o_thresh       (cfg_thresh),
    .o_clear        (cfg_clear)
  );

  moving_sum #(
    .SAMPLE_W (SAMPLE_W),
    .MAX_LEN  (MAX_LEN)
  ) mean_sum_inst (
    .clk     (clk),
    .i_rst   (i_rst),
    .i_clear (cfg_clear),
    .i_len   (cfg_len),
    .i_data  (i_tdata),
    .i_last  (i_tlast),
    .i_valid (mean_valid),
    .o_ready (mean_ready),
    .o_sum   (mean_sum),
    .o_last  (mean_last),
    .o_valid (mean_vld),
    .i_ready (mean_pop)
  );

  power_sum #(
    .SAMPLE_W (SAMPLE_W),
    .MAX_LEN  (MAX_LEN)
  ) power_sum_inst (
    .clk     (clk),
    .i_rst   (i_rst),
    .i_clear (cfg_clear),
    .i_len   (cfg_len),
    .i_data  (i_tdata),
    .i_valid (pow_valid),
    .o_ready (pow_ready),
    .o_pow   (pow_sum),
    .o_valid (pow_vld),
    .i_ready (pow_pop)
  );

  stats_join #(
    .SAMPLE_W       (SAMPLE_W),
    .MAX_LEN        (MAX_LEN)
  ) stats_join_inst (
    .clk            (clk),
    .i_rst          (i_rst),
    .i_clear        (cfg_clear),
    .i_len          (cfg_len),
    .i_thresh       (cfg_thresh),
    .i_tvalid       (i_tvalid),
    .o_tready       (o_tready_in),
    .o_mean_valid   (mean_valid),
    .o_pow_valid    (pow_valid),
    .i_mean_ready   (mean_ready),
    .i_pow_ready    (pow_ready),
    .i_mean         (mean_sum),
    .i_mean_last    (mean_last),
    .i_mean_vld     (mean_vld),
    .o_mean_pop     (mean_pop),
    .i_pow          (pow_sum),
    .i_pow_vld      (pow_vld),
    .o_pow_pop      (pow_pop),
    .o_metric       (o_metric),
    .o_detect       (o_detect),
    .o_tlast        (o_tlast),
    .o_tvalid       (o_tvalid),
    .i_tready       (i_out_ready),
    .o_detect_event (detect_event)
  );

endmodule
